/* hdl/mipsCtrl_params.svh */
`ifndef MIPS_CTRL_PARAMS_SVH
`define MIPS_CTRL_PARAMS_SVH

// instruction word
`define MIPS_INSTR_W 32

// field bounds
`define MIPS_OPCODE_HI 31
`define MIPS_OPCODE_LO 26
`define MIPS_RT_HI 20
`define MIPS_RT_LO 16
`define MIPS_FUNCT_HI 5
`define MIPS_FUNCT_LO 0

// rotate markers on the shift encodings
`define MIPS_ROT_BIT 21
`define MIPS_ROTV_BIT 6

`endif

/* hdl/mipsCtrl_pkg.sv */
`default_nettype none

package mipsCtrl_pkg;

	// alu operation codes
	typedef enum logic [5:0] {
		aluAdd = 6'b000000, aluSub = 6'b000001, aluAnd = 6'b000100,
		aluNor = 6'b000101, aluOr = 6'b000110, aluSll = 6'b000111,
		aluSra = 6'b001000, aluSrl = 6'b001001, aluXor = 6'b001010,
		aluSlt = 6'b001011, aluMovn = 6'b001100, aluMovz = 6'b001101,
		aluRotrv = 6'b001110, aluRotr = 6'b001111, aluLui = 6'b010000,
		aluBeq = 6'b010111, aluBgtz = 6'b011000, aluBlez = 6'b011001,
		aluBne = 6'b011010, aluBgez = 6'b011011, aluBltz = 6'b011100,
		aluSllv = 6'b100000, aluSrlv = 6'b100001, aluSrav = 6'b100010,
		aluJr = 6'b100100, aluJump = 6'b100101,
		aluInvalid = 6'b111111
	} aluOp_t;

	// memory access size
	typedef enum logic [1:0] {
		sizeWord = 2'b00,
		sizeHalf = 2'b01,
		sizeByte = 2'b10
	} dataOp_t;

	// primary opcodes
	localparam logic [5:0]
		opSpecial = 6'h00, opRegimm = 6'h01, opJ = 6'h02, opJal = 6'h03,
		opBeq = 6'h04, opBne = 6'h05, opBlez = 6'h06, opBgtz = 6'h07,
		opAddi = 6'h08, opAddiu = 6'h09, opSlti = 6'h0a, opSltiu = 6'h0b,
		opAndi = 6'h0c, opOri = 6'h0d, opXori = 6'h0e, opLui = 6'h0f,
		opLb = 6'h20, opLh = 6'h21, opLw = 6'h23,
		opSb = 6'h28, opSh = 6'h29, opSw = 6'h2b;

	// function field of special ops
	localparam logic [5:0]
		fnSll = 6'h00, fnSrl = 6'h02, fnSra = 6'h03, fnSllv = 6'h04,
		fnSrlv = 6'h06, fnSrav = 6'h07, fnJr = 6'h08, fnMovz = 6'h0a,
		fnMovn = 6'h0b, fnAdd = 6'h20, fnAddu = 6'h21, fnSub = 6'h22,
		fnAnd = 6'h24, fnOr = 6'h25, fnXor = 6'h26, fnNor = 6'h27,
		fnSlt = 6'h2a, fnSltu = 6'h2b;

	// rt selects within regimm
	localparam logic [4:0] rtBltz = 5'h00;
	localparam logic [4:0] rtBgez = 5'h01;

endpackage

`default_nettype wire

/* hdl/specialDecoder.sv */
`timescale 1ns/1ps
`default_nettype none
`include "mipsCtrl_params.svh"

module specialDecoder (
	input wire [`MIPS_INSTR_W-1:0] instruction,
	output mipsCtrl_pkg::aluOp_t aluControl,
	output logic regDst,
	output logic regWrite,
	output logic aluSrc2,
	output logic memRead,
	output logic memWrite,
	output logic memToReg,
	output logic pcSrcBranch,
	output logic pcSrcJump,
	output logic unsignedOp,
	output logic link,
	output mipsCtrl_pkg::dataOp_t dataOp
);

	logic [5:0] funct;
	logic rType;

	assign funct = instruction[`MIPS_FUNCT_HI:`MIPS_FUNCT_LO];

	always_comb begin
		aluControl = mipsCtrl_pkg::aluInvalid;
		rType = 1'b1;
		pcSrcJump = 1'b0;
		unsignedOp = 1'b0;
		case (funct)
			mipsCtrl_pkg::fnAdd: aluControl = mipsCtrl_pkg::aluAdd;
			mipsCtrl_pkg::fnAddu: begin
				aluControl = mipsCtrl_pkg::aluAdd;
				unsignedOp = 1'b1;
			end
			mipsCtrl_pkg::fnSub: aluControl = mipsCtrl_pkg::aluSub;
			mipsCtrl_pkg::fnAnd: aluControl = mipsCtrl_pkg::aluAnd;
			mipsCtrl_pkg::fnOr: aluControl = mipsCtrl_pkg::aluOr;
			mipsCtrl_pkg::fnNor: aluControl = mipsCtrl_pkg::aluNor;
			mipsCtrl_pkg::fnXor: aluControl = mipsCtrl_pkg::aluXor;
			mipsCtrl_pkg::fnSll: aluControl = mipsCtrl_pkg::aluSll;
			mipsCtrl_pkg::fnSllv: aluControl = mipsCtrl_pkg::aluSllv;
			mipsCtrl_pkg::fnSrl: begin
				// rs field bit picks rotate
				if (instruction[`MIPS_ROT_BIT]) begin
					aluControl = mipsCtrl_pkg::aluRotr;
				end else begin
					aluControl = mipsCtrl_pkg::aluSrl;
				end
			end
			mipsCtrl_pkg::fnSrlv: begin
				if (instruction[`MIPS_ROTV_BIT]) begin
					aluControl = mipsCtrl_pkg::aluRotrv;
				end else begin
					aluControl = mipsCtrl_pkg::aluSrlv;
				end
			end
			mipsCtrl_pkg::fnSra: aluControl = mipsCtrl_pkg::aluSra;
			mipsCtrl_pkg::fnSrav: aluControl = mipsCtrl_pkg::aluSrav;
			mipsCtrl_pkg::fnSlt: aluControl = mipsCtrl_pkg::aluSlt;
			mipsCtrl_pkg::fnSltu: begin
				aluControl = mipsCtrl_pkg::aluSlt;
				unsignedOp = 1'b1;
			end
			mipsCtrl_pkg::fnMovn: aluControl = mipsCtrl_pkg::aluMovn;
			mipsCtrl_pkg::fnMovz: aluControl = mipsCtrl_pkg::aluMovz;
			mipsCtrl_pkg::fnJr: begin
				// jump to rs, nothing written back
				aluControl = mipsCtrl_pkg::aluJr;
				rType = 1'b0;
				pcSrcJump = 1'b1;
			end
			default: rType = 1'b0;
		endcase
	end

	// register-register writeback
	assign regDst = rType;
	assign regWrite = rType;
	assign memToReg = rType;

	assign aluSrc2 = 1'b0;
	assign memRead = 1'b0;
	assign memWrite = 1'b0;
	assign pcSrcBranch = 1'b0;
	assign link = 1'b0;
	assign dataOp = mipsCtrl_pkg::sizeWord;

endmodule

`default_nettype wire

/* hdl/primaryDecoder.sv */
`timescale 1ns/1ps
`default_nettype none
`include "mipsCtrl_params.svh"

module primaryDecoder (
	input wire [`MIPS_INSTR_W-1:0] instruction,
	output mipsCtrl_pkg::aluOp_t aluControl,
	output logic regDst,
	output logic regWrite,
	output logic aluSrc2,
	output logic memRead,
	output logic memWrite,
	output logic memToReg,
	output logic pcSrcBranch,
	output logic pcSrcJump,
	output logic unsignedOp,
	output logic link,
	output mipsCtrl_pkg::dataOp_t dataOp
);

	logic [5:0] opcode;
	logic [4:0] rt;
	logic isImm;
	logic isLoad;
	logic isStore;

	assign opcode = instruction[`MIPS_OPCODE_HI:`MIPS_OPCODE_LO];
	assign rt = instruction[`MIPS_RT_HI:`MIPS_RT_LO];

	always_comb begin
		aluControl = mipsCtrl_pkg::aluInvalid;
		dataOp = mipsCtrl_pkg::sizeWord;
		isImm = 1'b0;
		isLoad = 1'b0;
		isStore = 1'b0;
		unsignedOp = 1'b0;
		pcSrcBranch = 1'b0;
		pcSrcJump = 1'b0;
		link = 1'b0;
		case (opcode)
			mipsCtrl_pkg::opAddi, mipsCtrl_pkg::opAddiu: begin
				isImm = 1'b1;
				aluControl = mipsCtrl_pkg::aluAdd;
			end
			mipsCtrl_pkg::opSlti, mipsCtrl_pkg::opSltiu: begin
				isImm = 1'b1;
				aluControl = mipsCtrl_pkg::aluSlt;
				unsignedOp = opcode == mipsCtrl_pkg::opSltiu;
			end
			mipsCtrl_pkg::opAndi: begin
				isImm = 1'b1;
				aluControl = mipsCtrl_pkg::aluAnd;
				unsignedOp = 1'b1;
			end
			mipsCtrl_pkg::opOri: begin
				isImm = 1'b1;
				aluControl = mipsCtrl_pkg::aluOr;
				unsignedOp = 1'b1;
			end
			mipsCtrl_pkg::opXori: begin
				isImm = 1'b1;
				aluControl = mipsCtrl_pkg::aluXor;
			end
			mipsCtrl_pkg::opLui: begin
				isImm = 1'b1;
				aluControl = mipsCtrl_pkg::aluLui;
			end
			// base plus offset address
			mipsCtrl_pkg::opLb, mipsCtrl_pkg::opLh, mipsCtrl_pkg::opLw: begin
				isLoad = 1'b1;
				aluControl = mipsCtrl_pkg::aluAdd;
			end
			mipsCtrl_pkg::opSb, mipsCtrl_pkg::opSh, mipsCtrl_pkg::opSw: begin
				isStore = 1'b1;
				aluControl = mipsCtrl_pkg::aluAdd;
			end
			mipsCtrl_pkg::opBeq: begin
				pcSrcBranch = 1'b1;
				aluControl = mipsCtrl_pkg::aluBeq;
			end
			mipsCtrl_pkg::opBne: begin
				pcSrcBranch = 1'b1;
				aluControl = mipsCtrl_pkg::aluBne;
			end
			mipsCtrl_pkg::opBgtz: begin
				pcSrcBranch = 1'b1;
				aluControl = mipsCtrl_pkg::aluBgtz;
			end
			mipsCtrl_pkg::opBlez: begin
				pcSrcBranch = 1'b1;
				aluControl = mipsCtrl_pkg::aluBlez;
			end
			mipsCtrl_pkg::opRegimm: begin
				// other rt values stay invalid
				if (rt == mipsCtrl_pkg::rtBgez) begin
					pcSrcBranch = 1'b1;
					aluControl = mipsCtrl_pkg::aluBgez;
				end else if (rt == mipsCtrl_pkg::rtBltz) begin
					pcSrcBranch = 1'b1;
					aluControl = mipsCtrl_pkg::aluBltz;
				end
			end
			mipsCtrl_pkg::opJ, mipsCtrl_pkg::opJal: begin
				pcSrcJump = 1'b1;
				aluControl = mipsCtrl_pkg::aluJump;
				link = opcode == mipsCtrl_pkg::opJal;
			end
			default: aluControl = mipsCtrl_pkg::aluInvalid;
		endcase
		// access size for loads and stores
		if (opcode == mipsCtrl_pkg::opLh || opcode == mipsCtrl_pkg::opSh) begin
			dataOp = mipsCtrl_pkg::sizeHalf;
		end else if (opcode == mipsCtrl_pkg::opLb || opcode == mipsCtrl_pkg::opSb) begin
			dataOp = mipsCtrl_pkg::sizeByte;
		end
	end

	// destination is always rt here
	assign regDst = 1'b0;
	assign aluSrc2 = isImm | isLoad | isStore;
	assign regWrite = isImm | isLoad | link;
	assign memToReg = isImm;
	assign memRead = isLoad;
	assign memWrite = isStore;

endmodule

`default_nettype wire

/* hdl/controlSelect.sv */
`timescale 1ns/1ps
`default_nettype none
`include "mipsCtrl_params.svh"

module controlSelect (
	input wire clk,
	input wire reset,
	input wire [`MIPS_INSTR_W-1:0] instruction,
	input wire req,
	input wire mipsCtrl_pkg::aluOp_t specAluControl,
	input wire specRegDst,
	input wire specRegWrite,
	input wire specAluSrc2,
	input wire specMemRead,
	input wire specMemWrite,
	input wire specMemToReg,
	input wire specPcSrcBranch,
	input wire specPcSrcJump,
	input wire specUnsignedOp,
	input wire specLink,
	input wire mipsCtrl_pkg::dataOp_t specDataOp,
	input wire mipsCtrl_pkg::aluOp_t primAluControl,
	input wire primRegDst,
	input wire primRegWrite,
	input wire primAluSrc2,
	input wire primMemRead,
	input wire primMemWrite,
	input wire primMemToReg,
	input wire primPcSrcBranch,
	input wire primPcSrcJump,
	input wire primUnsignedOp,
	input wire primLink,
	input wire mipsCtrl_pkg::dataOp_t primDataOp,
	output logic ack,
	output mipsCtrl_pkg::aluOp_t aluControl,
	output logic regDst,
	output logic regWrite,
	output logic aluSrc2,
	output logic memRead,
	output logic memWrite,
	output logic memToReg,
	output logic pcSrcBranch,
	output logic pcSrcJump,
	output logic unsignedOp,
	output logic link,
	output mipsCtrl_pkg::dataOp_t dataOp
);

	localparam int ALU_W = $bits(mipsCtrl_pkg::aluOp_t);
	localparam int DATA_W = $bits(mipsCtrl_pkg::dataOp_t);
	localparam int FLAG_W = 10;
	localparam int SET_W = ALU_W + FLAG_W + DATA_W;
	localparam logic [SET_W-1:0] RESET_SET =
		{mipsCtrl_pkg::aluInvalid, {FLAG_W{1'b0}}, mipsCtrl_pkg::sizeWord};

	logic [SET_W-1:0] specSet;
	logic [SET_W-1:0] primSet;
	logic [SET_W-1:0] setQ;
	logic isSpecial;

	assign isSpecial = instruction[`MIPS_OPCODE_HI:`MIPS_OPCODE_LO] == mipsCtrl_pkg::opSpecial;

	// flags in port order
	assign specSet = {specAluControl, specRegDst, specRegWrite, specAluSrc2, specMemRead,
		specMemWrite, specMemToReg, specPcSrcBranch, specPcSrcJump, specUnsignedOp,
		specLink, specDataOp};
	assign primSet = {primAluControl, primRegDst, primRegWrite, primAluSrc2, primMemRead,
		primMemWrite, primMemToReg, primPcSrcBranch, primPcSrcJump, primUnsignedOp,
		primLink, primDataOp};

	always_ff @(posedge clk) begin
		if (reset) begin
			ack <= 1'b0;
			setQ <= RESET_SET;
		end else if (req && !ack) begin
			// capture once per request, held until the next one
			ack <= 1'b1;
			setQ <= isSpecial ? specSet : primSet;
		end else if (!req) begin
			ack <= 1'b0;
		end
	end

	assign aluControl = mipsCtrl_pkg::aluOp_t'(setQ[SET_W-1 -: ALU_W]);
	assign {regDst, regWrite, aluSrc2, memRead, memWrite, memToReg, pcSrcBranch,
		pcSrcJump, unsignedOp, link} = setQ[DATA_W +: FLAG_W];
	assign dataOp = mipsCtrl_pkg::dataOp_t'(setQ[DATA_W-1:0]);

endmodule

`default_nettype wire

/* hdl/mipsController.sv */
`timescale 1ns/1ps
`default_nettype none
`include "mipsCtrl_params.svh"

module mipsController (
	input wire clk,
	input wire reset,
	input wire [`MIPS_INSTR_W-1:0] instruction,
	input wire req,
	output logic ack,
	output mipsCtrl_pkg::aluOp_t aluControl,
	output logic regDst,
	output logic regWrite,
	output logic aluSrc2,
	output logic memRead,
	output logic memWrite,
	output logic memToReg,
	output logic pcSrcBranch,
	output logic pcSrcJump,
	output logic unsignedOp,
	output logic link,
	output mipsCtrl_pkg::dataOp_t dataOp
);

	// decoder results
	mipsCtrl_pkg::aluOp_t specAluControl;
	mipsCtrl_pkg::aluOp_t primAluControl;
	mipsCtrl_pkg::dataOp_t specDataOp;
	mipsCtrl_pkg::dataOp_t primDataOp;
	logic specRegDst, specRegWrite, specAluSrc2, specMemRead, specMemWrite;
	logic specMemToReg, specPcSrcBranch, specPcSrcJump, specUnsignedOp, specLink;
	logic primRegDst, primRegWrite, primAluSrc2, primMemRead, primMemWrite;
	logic primMemToReg, primPcSrcBranch, primPcSrcJump, primUnsignedOp, primLink;

	specialDecoder specDec (
		.instruction(instruction),
		.aluControl(specAluControl),
		.regDst(specRegDst),
		.regWrite(specRegWrite),
		.aluSrc2(specAluSrc2),
		.memRead(specMemRead),
		.memWrite(specMemWrite),
		.memToReg(specMemToReg),
		.pcSrcBranch(specPcSrcBranch),
		.pcSrcJump(specPcSrcJump),
		.unsignedOp(specUnsignedOp),
		.link(specLink),
		.dataOp(specDataOp)
	);

	primaryDecoder primDec (
		.instruction(instruction),
		.aluControl(primAluControl),
		.regDst(primRegDst),
		.regWrite(primRegWrite),
		.aluSrc2(primAluSrc2),
		.memRead(primMemRead),
		.memWrite(primMemWrite),
		.memToReg(primMemToReg),
		.pcSrcBranch(primPcSrcBranch),
		.pcSrcJump(primPcSrcJump),
		.unsignedOp(primUnsignedOp),
		.link(primLink),
		.dataOp(primDataOp)
	);

	// port names match the signals above one for one
	controlSelect sel (.*);

endmodule

`default_nettype wire

/* bench/clockGen.sv */
`timescale 1ns/1ps
`default_nettype none

module clockGen (
	output logic clk,
	output logic reset
);

	// 40 ns period
	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// release on a falling edge, clear of the sampling edge
	initial begin
		reset = 1'b1;
		repeat (10) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
	end

endmodule

`default_nettype wire

/* bench/mipsController_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module mipsController_checker (
	input wire clk,
	input wire reset,
	input wire req,
	input wire ack,
	input wire mipsCtrl_pkg::aluOp_t aluControl,
	input wire regDst,
	input wire regWrite,
	input wire aluSrc2,
	input wire memRead,
	input wire memWrite,
	input wire memToReg,
	input wire pcSrcBranch,
	input wire pcSrcJump,
	input wire unsignedOp,
	input wire link,
	input wire mipsCtrl_pkg::dataOp_t dataOp
);

	int assertFails = 0;
	logic [17:0] ctrlSet;

	assign ctrlSet = {aluControl, regDst, regWrite, aluSrc2, memRead, memWrite,
		memToReg, pcSrcBranch, pcSrcJump, unsignedOp, link, dataOp};

	// ack only answers a request
	ackNeedsReq: assert property (@(posedge clk) disable iff (reset)
		$rose(ack) |-> $past(req))
	else begin
		assertFails++;
		$error("ack rose although req was low on the previous edge");
	end

	ackOneCycle: assert property (@(posedge clk) disable iff (reset)
		(req && !ack) |=> ack)
	else begin
		assertFails++;
		$error("ack did not rise one cycle after req was sampled high");
	end

	// set is frozen while acknowledged
	setStable: assert property (@(posedge clk) disable iff (reset)
		(ack && $past(ack)) |-> $stable(ctrlSet))
	else begin
		assertFails++;
		$error("control set changed while ack was held high");
	end

endmodule

bind mipsController mipsController_checker chk (.*);

`default_nettype wire

/* bench/mipsController_tb.sv */
`timescale 1ns/1ps
`default_nettype none
`include "mipsCtrl_params.svh"

module mipsController_tb;

	localparam int ACK_TIMEOUT = 20;
	localparam int RESET_TIMEOUT = 40;

	logic clk;
	logic reset;
	logic req;
	logic [`MIPS_INSTR_W-1:0] instruction;
	logic ack;
	mipsCtrl_pkg::aluOp_t aluControl;
	mipsCtrl_pkg::dataOp_t dataOp;
	logic regDst;
	logic regWrite;
	logic aluSrc2;
	logic memRead;
	logic memWrite;
	logic memToReg;
	logic pcSrcBranch;
	logic pcSrcJump;
	logic unsignedOp;
	logic link;
	logic [9:0] flags;

	int errors;
	int timeouts;
	int tests;
	integer seed;

	clockGen clkGen (
		.clk(clk),
		.reset(reset)
	);

	mipsController uut (.*);

	// same bit order as the golden file
	assign flags = {regDst, regWrite, aluSrc2, memRead, memWrite, memToReg,
		pcSrcBranch, pcSrcJump, unsignedOp, link};

	task automatic checkAluOp(input string tag, input mipsCtrl_pkg::aluOp_t exp,
		input mipsCtrl_pkg::aluOp_t act);
		if (act !== exp) begin
			errors++;
			$display("MISMATCH %s aluControl expected %h (%s) actual %h (%s)",
				tag, exp, exp.name(), act, act.name());
		end
	endtask

	task automatic checkDataOp(input string tag, input mipsCtrl_pkg::dataOp_t exp,
		input mipsCtrl_pkg::dataOp_t act);
		if (act !== exp) begin
			errors++;
			$display("MISMATCH %s dataOp expected %h actual %h", tag, exp, act);
		end
	endtask

	task automatic checkFlags(input string tag, input logic [9:0] exp, input logic [9:0] act);
		if (act !== exp) begin
			errors++;
			$display("MISMATCH %s flags expected %b actual %b", tag, exp, act);
		end
	endtask

	task automatic checkAck(input string tag, input logic exp, input logic act);
		if (act !== exp) begin
			errors++;
			$display("MISMATCH %s ack expected %b actual %b", tag, exp, act);
		end
	endtask

	task automatic checkLatency(input string tag, input int exp, input int act);
		if (act != exp) begin
			errors++;
			$display("MISMATCH %s ack latency expected %0d actual %0d", tag, exp, act);
		end
	endtask

	// sampled on falling edges away from the DUT's clock edge
	task automatic waitAck(input logic level, input string tag, output int cycles);
		cycles = 0;
		do begin
			@(negedge clk);
			cycles++;
		end while (ack !== level && cycles < ACK_TIMEOUT);
		if (ack !== level) begin
			timeouts++;
			$display("timeout in %s: ack did not reach %b within %0d cycles",
				tag, level, ACK_TIMEOUT);
		end
	endtask

	initial begin
		int fd;
		int rc;
		int gap;
		int hold;
		int cycles;
		int n;
		bit done;
		string tag;
		string idleTag;
		logic [8*24-1:0] testName;
		logic [8*120-1:0] rest;
		logic [`MIPS_INSTR_W-1:0] instrIn;
		logic [5:0] aluRaw;
		logic [1:0] sizeRaw;
		logic [9:0] flagsExp;
		mipsCtrl_pkg::aluOp_t lastAlu;
		mipsCtrl_pkg::dataOp_t lastSize;
		logic [9:0] lastFlags;

		req = 1'b0;
		instruction = '0;
		errors = 0;
		timeouts = 0;
		tests = 0;
		seed = 32'h00c9ecdd;
		done = 1'b0;
		fd = 0;
		n = 0;

		do begin
			@(posedge clk);
			n++;
		end while (reset !== 1'b0 && n < RESET_TIMEOUT);
		if (reset !== 1'b0) begin
			timeouts++;
			$display("timeout: reset was never released");
			done = 1'b1;
		end

		if (!done) begin
			// state straight out of reset
			lastAlu = mipsCtrl_pkg::aluInvalid;
			lastFlags = '0;
			lastSize = mipsCtrl_pkg::sizeWord;
			@(negedge clk);
			checkAck("reset", 1'b0, ack);
			checkAluOp("reset", lastAlu, aluControl);
			checkFlags("reset", lastFlags, flags);
			checkDataOp("reset", lastSize, dataOp);

			fd = $fopen("bench/decode_golden.txt", "r");
			if (fd == 0) begin
				errors++;
				$display("could not open bench/decode_golden.txt");
				done = 1'b1;
			end
		end

		while (!done && timeouts == 0) begin
			rc = $fscanf(fd, "%s", testName);
			if (rc != 1) begin
				done = 1'b1;
			end else if (testName[7:0] == "#") begin
				rc = $fgets(rest, fd);
			end else begin
				rc = $fscanf(fd, "%h %h %b %h", instrIn, aluRaw, flagsExp, sizeRaw);
				if (rc != 4) begin
					errors++;
					$display("golden line for %0s is malformed", testName);
					done = 1'b1;
				end else begin
					tests++;
					tag = $sformatf("%0s", testName);
					idleTag = {"idle before ", tag};

					// last set must hold through the idle gap
					gap = $random(seed) & 3;
					for (int i = 0; i < gap; i++) begin
						@(negedge clk);
						checkAluOp(idleTag, lastAlu, aluControl);
						checkFlags(idleTag, lastFlags, flags);
						checkDataOp(idleTag, lastSize, dataOp);
					end

					instruction = instrIn;
					req = 1'b1;
					waitAck(1'b1, tag, cycles);
					if (timeouts == 0) begin
						checkLatency(tag, 1, cycles);
						lastAlu = mipsCtrl_pkg::aluOp_t'(aluRaw);
						lastFlags = flagsExp;
						lastSize = mipsCtrl_pkg::dataOp_t'(sizeRaw);
						checkAluOp(tag, lastAlu, aluControl);
						checkFlags(tag, lastFlags, flags);
						checkDataOp(tag, lastSize, dataOp);

						// ack stays up while the requester stalls
						hold = $random(seed) & 1;
						for (int i = 0; i < hold; i++) begin
							// a new word must not be captured
							instruction = $random(seed);
							@(negedge clk);
							checkAck(tag, 1'b1, ack);
							checkAluOp(tag, lastAlu, aluControl);
							checkFlags(tag, lastFlags, flags);
							checkDataOp(tag, lastSize, dataOp);
						end

						req = 1'b0;
						instruction = $random(seed);
						waitAck(1'b0, tag, cycles);
					end
					if (timeouts == 0) begin
						checkLatency(tag, 1, cycles);
						checkAluOp(tag, lastAlu, aluControl);
						checkFlags(tag, lastFlags, flags);
						checkDataOp(tag, lastSize, dataOp);
					end
				end
			end
		end

		if (fd != 0) begin
			$fclose(fd);
		end
		$display("tests=%0d mismatches=%0d timeouts=%0d assertion failures=%0d",
			tests, errors, timeouts, uut.chk.assertFails);
		if (errors == 0 && timeouts == 0 && uut.chk.assertFails == 0 && tests > 0) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* bench/decode_golden.txt */
# columns: name instruction(hex) aluCode(hex) flags(binary) dataOp(hex)
# flags: regDst regWrite aluSrc2 memRead memWrite memToReg branch jump unsigned link
add      00221820 00 1100010000 0
addu     00221821 00 1100010010 0
sub      00221822 01 1100010000 0
and      00221824 04 1100010000 0
or       00221825 06 1100010000 0
nor      00221827 05 1100010000 0
xor      00221826 0a 1100010000 0
slt      0022182a 0b 1100010000 0
sltu     0022182b 0b 1100010010 0
movz     0022180a 0d 1100010000 0
movn     0022180b 0c 1100010000 0
sll      00021900 07 1100010000 0
sllv     00221804 20 1100010000 0
srl      00021902 09 1100010000 0
rotr     00221902 0f 1100010000 0
sra      00021903 08 1100010000 0
srav     00221807 22 1100010000 0
srlv     00221806 21 1100010000 0
rotrv    00221846 0e 1100010000 0
jr       03e00008 24 0000000100 0
badFunct 0022183f 3f 0000000000 0
mult     00221818 3f 0000000000 0
addi     20221234 00 0110010000 0
addiu    24221234 00 0110010000 0
slti     28221234 0b 0110010000 0
sltiu    2c221234 0b 0110010010 0
andi     30221234 04 0110010010 0
ori      34221234 06 0110010010 0
xori     38221234 0a 0110010000 0
lui      3c021234 10 0110010000 0
lw       8c220010 00 0111000000 0
lh       84220010 00 0111000000 1
lb       80220010 00 0111000000 2
sw       ac220010 00 0010100000 0
sh       a4220010 00 0010100000 1
sb       a0220010 00 0010100000 2
beq      10220004 17 0000001000 0
bne      14220004 1a 0000001000 0
blez     18200004 19 0000001000 0
bgtz     1c200004 18 0000001000 0
bltz     04200004 1c 0000001000 0
bgez     04210004 1b 0000001000 0
bgezal   04310004 3f 0000000000 0
j        08000100 25 0000000100 0
jal      0c000100 25 0100000101 0
mul      70221802 3f 0000000000 0
badOp    fc000000 3f 0000000000 0

/* list.f */
+incdir+hdl
hdl/mipsCtrl_pkg.sv
hdl/specialDecoder.sv
hdl/primaryDecoder.sv
hdl/controlSelect.sv
hdl/mipsController.sv
bench/clockGen.sv
bench/mipsController_checker.sv
bench/mipsController_tb.sv

/* Makefile */
TOP = mipsController_tb

.PHONY: run lint clean

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) +verilator+error+limit+100 | tee sim.log
	grep -q "^ALL CHECKS PASSED$$" sim.log

obj_dir/V$(TOP): list.f hdl/*.sv hdl/*.svh bench/*.sv
	verilator --binary --timing --assert -f list.f --top-module $(TOP) -Mdir obj_dir

lint:
	verilator --lint-only --timing --assert -f list.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log
